// ==== hdl/acum_types_pkg.sv ====
// data widths and types shared by the sample stream and the accumulator
// sample width is fixed by the ADC front end, sums hold the full pass count

package acum_types_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int IDW = 14;         // sample width
  localparam int ACW = 32;         // pass counter and frame length width
  localparam int ODW = IDW + ACW;  // bin sum width, no overflow possible

  //////////////////////////////
  // types
  //////////////////////////////

  // one signed ADC sample
  typedef logic signed [IDW-1:0] sample_t;

  // pass count or frame length
  typedef logic [ACW-1:0] cnt_t;

  // accumulated bin, two's complement
  typedef logic signed [ODW-1:0] sum_t;

  // register bus word
  typedef logic [31:0] word_t;

endpackage : acum_types_pkg

// ==== hdl/acum_regs_pkg.sv ====
// register map of the averager
// byte addresses on a 12-bit register bus, bin memory mapped in two windows

package acum_regs_pkg;

  typedef logic [11:0] reg_adr_t;  // byte address

  //////////////////////////////
  // register offsets
  //////////////////////////////

  localparam reg_adr_t REG_CTRL    = 12'h000;  // run, clear pulse
  localparam reg_adr_t REG_CFG_CNT = 12'h004;  // passes minus one
  localparam reg_adr_t REG_CFG_LEN = 12'h008;  // frame length minus one
  localparam reg_adr_t REG_STS_CNT = 12'h00C;  // current pass index
  localparam reg_adr_t REG_STS     = 12'h010;  // sticky done

  // bin memory windows, one word per bin
  localparam reg_adr_t MEM_LO_BASE = 12'h400;  // low 32 bits
  localparam reg_adr_t MEM_HI_BASE = 12'h800;  // top bits, sign extended

  // REG_CTRL bit positions
  localparam int CTRL_RUN = 0;
  localparam int CTRL_CLR = 1;

endpackage : acum_regs_pkg

// ==== hdl/frame_slicer.sv ====
// cuts one frame out of the ADC stream after each trigger sample
// frame is cfg_len+1 samples long, last sample marked with sti_tlast

`timescale 1ns/10ps

module frame_slicer #(
  parameter int AAW = 6  // bin address width, caps the frame length
)(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    run,
  input  acum_types_pkg::cnt_t    cfg_len,     // frame length minus one
  // ADC side
  input  acum_types_pkg::sample_t adc_dat,
  input  logic                    adc_vld,
  input  logic                    trg,         // frame start strobe
  output logic                    adc_rdy,
  // stream to the core
  output acum_types_pkg::sample_t sti_tdata,
  output logic                    sti_tvalid,
  output logic                    sti_tlast,
  input  logic                    sti_tready
);

  typedef enum logic {IDLE, FRAME} state_t;

  // never run past the last bin
  localparam acum_types_pkg::cnt_t BIN_MAX = acum_types_pkg::cnt_t'(2**AAW - 1);

  state_t               state;
  acum_types_pkg::cnt_t cnt;     // samples accepted in this frame
  logic                 open;    // sample belongs to a frame
  logic                 trnsfr;

  // trigger sample opens the frame in the same cycle
  assign open = run & ((state == FRAME) | trg);

  assign sti_tdata  = adc_dat;                        // no latency
  assign sti_tvalid = adc_vld & open;
  assign sti_tlast  = (cnt == cfg_len) | (cnt == BIN_MAX);
  assign adc_rdy    = open ? sti_tready : 1'b1;       // drop samples between frames

  assign trnsfr = sti_tvalid & sti_tready;

  //////////////////////////////
  // frame FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      cnt   <= '0;
    end else if (!run) begin
      state <= IDLE;  // stopping aborts an open frame
      cnt   <= '0;
    end else if (trnsfr) begin
      if (sti_tlast) begin
        state <= IDLE;
        cnt   <= '0;
      end else begin
        state <= FRAME;    // triggers inside a frame are ignored
        cnt   <= cnt + 1;
      end
    end
  end

endmodule : frame_slicer

// ==== hdl/acum_regs.sv ====
// control and status registers of the averager
// also maps the bin RAM as low and high words readable while stopped
// reads answer with reg_rvld two cycles after reg_ren

`timescale 1ns/10ps

module acum_regs #(
  parameter int AAW = 6  // bin address width
)(
  input  logic                     clk,
  input  logic                     rst,
  // register port
  input  logic                     reg_wen,
  input  logic                     reg_ren,
  input  acum_regs_pkg::reg_adr_t  reg_adr,
  input  acum_types_pkg::word_t    reg_wdt,
  output acum_types_pkg::word_t    reg_rdt,
  output logic                     reg_rvld,
  // core control and status
  output logic                     run,
  output logic                     clr,
  output acum_types_pkg::cnt_t     cfg_cnt,
  output acum_types_pkg::cnt_t     cfg_len,
  input  acum_types_pkg::cnt_t     sts_cnt,
  input  logic                     sts_end,
  // bin memory read
  output logic                     bus_ren,
  output logic [AAW-1:0]           bus_adr,
  input  acum_types_pkg::sum_t     bus_rdt,
  output logic                     irq_done
);

  localparam int ODW = acum_types_pkg::ODW;

  localparam logic [1:0] SRC_REG = 2'd0;  // register word
  localparam logic [1:0] SRC_LO  = 2'd1;  // bin low word
  localparam logic [1:0] SRC_HI  = 2'd2;  // bin high word
  localparam logic [1:0] SRC_NUL = 2'd3;  // window read while running

  logic                  done;      // sticky end of run
  logic                  wr_ctrl;
  logic                  in_lo;
  logic                  in_hi;
  logic                  rd_vld;    // first read stage
  logic [1:0]            rd_src;
  acum_types_pkg::word_t rd_word;
  acum_types_pkg::word_t reg_mux;

  assign wr_ctrl = reg_wen & (reg_adr == acum_regs_pkg::REG_CTRL);

  // window decode on the top address bits
  assign in_lo = reg_adr[11:10] == acum_regs_pkg::MEM_LO_BASE[11:10];
  assign in_hi = reg_adr[11:10] == acum_regs_pkg::MEM_HI_BASE[11:10];

  // bin index from the word address
  assign bus_ren = reg_ren & (in_lo | in_hi) & ~run;  // RAM read only while stopped
  assign bus_adr = reg_adr[AAW+1:2];

  assign irq_done = done;

  // core clears on the same edge as the write
  assign clr = wr_ctrl & reg_wdt[acum_regs_pkg::CTRL_CLR];  // single cycle

  //////////////////////////////
  // write side
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      run     <= 1'b0;
      done    <= 1'b0;
      cfg_cnt <= '0;
      cfg_len <= '0;
    end else begin
      if (wr_ctrl)
        run <= reg_wdt[acum_regs_pkg::CTRL_RUN];
      else if (sts_end)
        run <= 1'b0;                                      // last pass done
      if (sts_end)
        done <= 1'b1;
      else if (wr_ctrl & reg_wdt[acum_regs_pkg::CTRL_RUN])
        done <= 1'b0;                                     // new run
      if (reg_wen & (reg_adr == acum_regs_pkg::REG_CFG_CNT)) cfg_cnt <= reg_wdt;
      if (reg_wen & (reg_adr == acum_regs_pkg::REG_CFG_LEN)) cfg_len <= reg_wdt;
    end
  end

  //////////////////////////////
  // read side
  //////////////////////////////

  always_comb begin
    case (reg_adr)
      acum_regs_pkg::REG_CTRL:    reg_mux = {31'd0, run};
      acum_regs_pkg::REG_CFG_CNT: reg_mux = cfg_cnt;
      acum_regs_pkg::REG_CFG_LEN: reg_mux = cfg_len;
      acum_regs_pkg::REG_STS_CNT: reg_mux = sts_cnt;
      acum_regs_pkg::REG_STS:     reg_mux = {31'd0, done};
      default:                    reg_mux = '0;
    endcase
  end

  // stage 1 runs alongside the RAM read
  always_ff @(posedge clk) begin
    if (rst) rd_vld <= 1'b0;
    else     rd_vld <= reg_ren;
  end

  always_ff @(posedge clk) begin
    rd_word <= reg_mux;
    if (run & (in_lo | in_hi)) rd_src <= SRC_NUL;
    else if (in_lo)            rd_src <= SRC_LO;
    else if (in_hi)            rd_src <= SRC_HI;
    else                       rd_src <= SRC_REG;
  end

  // stage 2 output register
  always_ff @(posedge clk) begin
    if (rst) reg_rvld <= 1'b0;
    else     reg_rvld <= rd_vld;
  end

  always_ff @(posedge clk) begin
    case (rd_src)
      SRC_LO:  reg_rdt <= bus_rdt[31:0];
      SRC_HI:  reg_rdt <= {{(64-ODW){bus_rdt[ODW-1]}}, bus_rdt[ODW-1:32]};  // sign extend
      SRC_REG: reg_rdt <= rd_word;
      default: reg_rdt <= '0;
    endcase
  end

endmodule : acum_regs

// ==== hdl/acum_core.sv ====
// repeating accumulator, adds each frame bin by bin into a block RAM
// read, add and write take three cycles, the last pass streams the sums out
// the RAM read port goes to the register window while stopped

`timescale 1ns/10ps

module acum_core #(
  parameter int AAW = 6  // bin address width
)(
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clr,         // sync clear
  input  acum_types_pkg::cnt_t    cfg_cnt,     // passes minus one
  input  logic                    ctl_run,
  // status
  output acum_types_pkg::cnt_t    sts_cnt,     // current pass
  output logic                    sts_end,     // tlast of the last pass
  // input stream
  input  acum_types_pkg::sample_t sti_tdata,
  input  logic                    sti_tvalid,
  input  logic                    sti_tlast,
  output logic                    sti_tready,
  // result stream
  output acum_types_pkg::sum_t    sto_tdata,
  output logic                    sto_tvalid,
  output logic                    sto_tlast,
  input  logic                    sto_tready,
  // bin read port
  input  logic                    bus_ren,
  input  logic [AAW-1:0]          bus_adr,
  output acum_types_pkg::sum_t    bus_rdt
);

  localparam int IDW = acum_types_pkg::IDW;
  localparam int ODW = acum_types_pkg::ODW;

  logic                    sti_trnsfr;

  // pass counter
  acum_types_pkg::cnt_t    acu_cnt;
  logic                    acu_end;  // last pass
  logic                    acu_beg;  // first pass, one cycle late

  // stage 1 buffer
  acum_types_pkg::sample_t buf_tdata;
  logic                    buf_tlast;
  logic                    buf_lst;

  // stage 2 flags
  logic                    wr_tlast;
  logic                    wr_lst;

  // bin memory
  acum_types_pkg::sum_t    mem [0:2**AAW-1];
  logic [AAW-1:0]          mem_adr;              // stream address counter
  logic [AAW-1:0]          mem_tad, mem_wad, mem_rad;
  logic                    mem_ten, mem_wen, mem_ren;
  acum_types_pkg::sum_t    mem_rdt;
  acum_types_pkg::sum_t    mem_old;              // stored value, zero on pass 0
  acum_types_pkg::sum_t    mem_tdt;              // partial sum
  acum_types_pkg::sum_t    mem_wdt;
  logic                    mem_tcr;              // carry out of low part
  logic                    mem_tsg;              // sample sign
  logic [ODW-IDW-1:0]      mem_tts;              // high part correction

  assign sti_trnsfr = sti_tvalid & sti_tready;
  assign sti_tready = sto_tready;  // no result buffer

  //////////////////////////////
  // pass counter
  //////////////////////////////

  assign acu_end = (acu_cnt == cfg_cnt);
  assign sts_cnt = acu_cnt;
  assign sts_end = sti_trnsfr & sti_tlast & acu_end;

  always_ff @(posedge clk) begin
    if (rst | clr)
      acu_cnt <= '0;
    else if (sti_trnsfr & sti_tlast)
      acu_cnt <= acu_end ? '0 : acu_cnt + 1;  // wrap after last pass
  end

  // lines up with the add stage
  always_ff @(posedge clk) begin
    if (rst | clr) acu_beg <= 1'b0;
    else           acu_beg <= (acu_cnt == '0);
  end

  //////////////////////////////
  // pipeline
  //////////////////////////////

  // bin address, back to 0 after tlast
  always_ff @(posedge clk) begin
    if (rst | clr)
      mem_adr <= '0;
    else if (sti_trnsfr)
      mem_adr <= sti_tlast ? '0 : mem_adr + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst | clr) begin
      mem_ten <= 1'b0;
      mem_wen <= 1'b0;
    end else begin
      mem_ten <= sti_trnsfr;  // add stage valid
      mem_wen <= mem_ten;     // write stage valid
    end
  end

  always_ff @(posedge clk) begin
    if (sti_trnsfr) begin
      buf_tdata <= sti_tdata;
      buf_tlast <= sti_tlast;
      buf_lst   <= acu_end;
      mem_tad   <= mem_adr;
    end
    if (mem_ten) begin
      wr_tlast  <= buf_tlast;
      wr_lst    <= buf_lst;
      mem_wad   <= mem_tad;   // write address trails the read
    end
  end

  // split add, low part with carry, high part fixed up next cycle
  assign mem_old = acu_beg ? '0 : mem_rdt;

  always_ff @(posedge clk) begin
    if (mem_ten) begin
      mem_tdt[ODW-1:IDW]          <= mem_old[ODW-1:IDW];
      {mem_tcr, mem_tdt[IDW-1:0]} <= {1'b0, mem_old[IDW-1:0]} + {1'b0, buf_tdata};
      mem_tsg                     <= buf_tdata[IDW-1];
    end
  end

  // carry minus sign of the sample
  assign mem_tts = {(ODW-IDW){mem_tsg}} + {{(ODW-IDW-1){1'b0}}, mem_tcr};
  assign mem_wdt = {mem_tdt[ODW-1:IDW] + mem_tts, mem_tdt[IDW-1:0]};

  //////////////////////////////
  // RAM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (mem_wen) mem[mem_wad] <= mem_wdt;
  end

  // stream owns the read port while running
  assign mem_ren = ctl_run ? sti_trnsfr : bus_ren;
  assign mem_rad = ctl_run ? mem_adr : bus_adr;

  always_ff @(posedge clk) begin
    if (mem_ren) mem_rdt <= mem[mem_rad];
  end

  assign bus_rdt = mem_rdt;

  //////////////////////////////
  // result stream
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst | clr) sto_tvalid <= 1'b0;
    else           sto_tvalid <= mem_wen & wr_lst;  // last pass only
  end

  always_ff @(posedge clk) begin
    if (mem_wen & wr_lst) begin
      sto_tdata <= mem_wdt;
      sto_tlast <= wr_tlast;
    end
  end

endmodule : acum_core

// ==== hdl/averager_top.sv ====
// repeating signal averager, top level
// ADC samples in, bin sums out, register port for control and bin readback

`timescale 1ns/10ps

module averager_top #(
  parameter int AAW = 6  // bin address width, 64 bins
)(
  input  logic                    clk,
  input  logic                    rst,
  // sample input
  input  acum_types_pkg::sample_t adc_dat,
  input  logic                    adc_vld,
  input  logic                    trg,
  output logic                    adc_rdy,
  // result stream
  output acum_types_pkg::sum_t    sum_tdata,
  output logic                    sum_tlast,
  output logic                    sum_tvalid,
  input  logic                    sum_tready,
  // register port
  input  logic                    reg_wen,
  input  logic                    reg_ren,
  input  acum_regs_pkg::reg_adr_t reg_adr,
  input  acum_types_pkg::word_t   reg_wdt,
  output acum_types_pkg::word_t   reg_rdt,
  output logic                    reg_rvld,
  output logic                    irq_done
);

  logic                    run;
  logic                    clr;
  acum_types_pkg::cnt_t    cfg_cnt;
  acum_types_pkg::cnt_t    cfg_len;
  acum_types_pkg::cnt_t    sts_cnt;
  logic                    sts_end;
  // slicer to core
  acum_types_pkg::sample_t sti_tdata;
  logic                    sti_tvalid;
  logic                    sti_tlast;
  logic                    sti_tready;
  // register window to RAM
  logic                    bus_ren;
  logic [AAW-1:0]          bus_adr;
  acum_types_pkg::sum_t    bus_rdt;

  frame_slicer #(.AAW(AAW)) u_slicer (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .cfg_len    (cfg_len),
    .adc_dat    (adc_dat),
    .adc_vld    (adc_vld),
    .trg        (trg),
    .adc_rdy    (adc_rdy),
    .sti_tdata  (sti_tdata),
    .sti_tvalid (sti_tvalid),
    .sti_tlast  (sti_tlast),
    .sti_tready (sti_tready)
  );

  acum_regs #(.AAW(AAW)) u_regs (
    .clk      (clk),
    .rst      (rst),
    .reg_wen  (reg_wen),
    .reg_ren  (reg_ren),
    .reg_adr  (reg_adr),
    .reg_wdt  (reg_wdt),
    .reg_rdt  (reg_rdt),
    .reg_rvld (reg_rvld),
    .run      (run),
    .clr      (clr),
    .cfg_cnt  (cfg_cnt),
    .cfg_len  (cfg_len),
    .sts_cnt  (sts_cnt),
    .sts_end  (sts_end),
    .bus_ren  (bus_ren),
    .bus_adr  (bus_adr),
    .bus_rdt  (bus_rdt),
    .irq_done (irq_done)
  );

  acum_core #(.AAW(AAW)) u_core (
    .clk        (clk),
    .rst        (rst),
    .clr        (clr),
    .cfg_cnt    (cfg_cnt),
    .ctl_run    (run),
    .sts_cnt    (sts_cnt),
    .sts_end    (sts_end),
    .sti_tdata  (sti_tdata),
    .sti_tvalid (sti_tvalid),
    .sti_tlast  (sti_tlast),
    .sti_tready (sti_tready),
    .sto_tdata  (sum_tdata),
    .sto_tvalid (sum_tvalid),
    .sto_tlast  (sum_tlast),
    .sto_tready (sum_tready),
    .bus_ren    (bus_ren),
    .bus_adr    (bus_adr),
    .bus_rdt    (bus_rdt)
  );

endmodule : averager_top

// ==== tb/tb_averager.sv ====
// testbench for the repeating signal averager
// sends random triggered frames, checks the result stream against a reference
// model, then reads the bins back through the memory window

`timescale 1ns/10ps

module tb_averager;

  localparam int AAW  = 6;
  localparam int IDW  = acum_types_pkg::IDW;
  localparam int ODW  = acum_types_pkg::ODW;
  localparam int NBIN = 16;     // frame length of every run
  localparam int TMO  = 4000;   // cycles allowed per wait loop

  logic                    clk = 1'b0;
  logic                    rst;
  acum_types_pkg::sample_t adc_dat;
  logic                    adc_vld;
  logic                    trg;
  logic                    adc_rdy;
  acum_types_pkg::sum_t    sum_tdata;
  logic                    sum_tlast;
  logic                    sum_tvalid;
  logic                    sum_tready;
  logic                    reg_wen;
  logic                    reg_ren;
  acum_regs_pkg::reg_adr_t reg_adr;
  acum_types_pkg::word_t   reg_wdt;
  acum_types_pkg::word_t   reg_rdt;
  logic                    reg_rvld;
  logic                    irq_done;

  integer                  seed = 32'he90e_3c07;
  integer                  rnd;
  acum_types_pkg::sample_t stim [0:3][0:63];  // one frame per pass
  acum_types_pkg::sum_t    exp_sum [0:63];    // reference bins
  int                      beat_total = 0;    // beats seen by the monitor
  int                      beat_base;         // beat_total at run start
  int                      exp_bins;          // beats expected in this run
  logic                    bp_on;             // random back-pressure
  logic                    bp_pat [0:1023];
  logic [9:0]              bp_idx = '0;
  logic                    bp_bit = 1'b1;

  always #20 clk = ~clk;  // 40 ns period

  averager_top #(.AAW(AAW)) uut (
    .clk        (clk),
    .rst        (rst),
    .adc_dat    (adc_dat),
    .adc_vld    (adc_vld),
    .trg        (trg),
    .adc_rdy    (adc_rdy),
    .sum_tdata  (sum_tdata),
    .sum_tlast  (sum_tlast),
    .sum_tvalid (sum_tvalid),
    .sum_tready (sum_tready),
    .reg_wen    (reg_wen),
    .reg_ren    (reg_ren),
    .reg_adr    (reg_adr),
    .reg_wdt    (reg_wdt),
    .reg_rdt    (reg_rdt),
    .reg_rvld   (reg_rvld),
    .irq_done   (irq_done)
  );

  // ready pattern replayed on falling edges
  always @(negedge clk) begin
    bp_bit = bp_pat[bp_idx];
    bp_idx = bp_idx + 10'd1;  // wraps at 1024
  end

  assign sum_tready = bp_on ? bp_bit : 1'b1;

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic check_word(input acum_types_pkg::word_t act,
                            input acum_types_pkg::word_t exp, input string what);
    if (act !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %h, expected %h", $time, what, act, exp);
      $display("Result: FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_sum(input acum_types_pkg::sum_t act,
                           input acum_types_pkg::sum_t exp, input string what);
    if (act !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %h, expected %h", $time, what, act, exp);
      $display("Result: FAILED");
      $fatal(1, "sum mismatch");
    end
  endtask

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("[ERROR] t=%0d ns: %s is %b, expected %b", $time, what, act, exp);
      $display("Result: FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("Result: FAILED");
    $fatal(1, "wait loop timed out");
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic acum_types_pkg::sum_t sign_extend(input acum_types_pkg::sample_t s);
    return {{(ODW-IDW){s[IDW-1]}}, s};
  endfunction

  // expected bin is the sum over all passes starting from zero
  function automatic void compute_reference(input int npass);
    int b;
    int p;
    for (b = 0; b < NBIN; b++) begin
      exp_sum[b] = '0;
      for (p = 0; p < npass; p++)
        exp_sum[b] = exp_sum[b] + sign_extend(stim[p][b]);
    end
  endfunction

  // result monitor counts beats whatever sum_tready does
  always @(negedge clk) begin
    if (sum_tvalid === 1'b1) begin
      if (beat_total - beat_base >= exp_bins) begin
        $display("unexpected result beat at %0d ns, more sums than bins", $time);
        $display("Result: FAILED");
        $fatal(1, "extra result beat");
      end else begin
        check_sum(sum_tdata, exp_sum[beat_total - beat_base], "result bin");
        check_flag(sum_tlast, (beat_total - beat_base) == exp_bins - 1, "result tlast");
        beat_total = beat_total + 1;
      end
    end
  end

  //////////////////////////////
  // bus and stream tasks
  //////////////////////////////

  task automatic reg_write(input acum_regs_pkg::reg_adr_t adr,
                           input acum_types_pkg::word_t dat);
    reg_wen = 1'b1;
    reg_adr = adr;
    reg_wdt = dat;
    @(negedge clk);
    reg_wen = 1'b0;
  endtask

  task automatic reg_read(input acum_regs_pkg::reg_adr_t adr,
                          output acum_types_pkg::word_t dat);
    int n;
    n       = 0;
    reg_ren = 1'b1;
    reg_adr = adr;
    @(negedge clk);
    reg_ren = 1'b0;
    while (reg_rvld !== 1'b1 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (reg_rvld !== 1'b1) stop_on_timeout("register read data");
    dat = reg_rdt;
  endtask

  // hold one sample until the slicer takes it
  task automatic send_sample(input acum_types_pkg::sample_t dat, input logic start);
    int   n;
    logic took;
    n       = 0;
    took    = 1'b0;
    adc_dat = dat;
    adc_vld = 1'b1;
    trg     = start;
    while (!took && n < TMO) begin
      @(posedge clk);
      took = adc_rdy;  // valid is high, so ready means accepted
      @(negedge clk);
      n++;
    end
    if (!took) stop_on_timeout("slicer to accept a sample");
  endtask

  task automatic send_frame(input int p);
    int i;
    for (i = 0; i < NBIN; i++) begin
      rnd = $random(seed);
      send_sample(stim[p][i], (i == 0) || (rnd[3:0] == 4'd0));  // stray triggers too
    end
    adc_vld = 1'b0;
    trg     = 1'b0;
  endtask

  // idle cycles, then samples without trigger that must be dropped
  task automatic send_gap();
    int i;
    rnd = $random(seed);
    for (i = 0; i <= int'(rnd[1:0]); i++) begin
      adc_vld = 1'b0;
      @(negedge clk);
    end
    for (i = 0; i <= int'(rnd[4:2]); i++) begin
      adc_dat = rnd[IDW+7:8];
      adc_vld = 1'b1;
      trg     = 1'b0;
      @(negedge clk);
    end
    adc_vld = 1'b0;
  endtask

  task automatic make_frames(input int npass);
    int p;
    int i;
    for (p = 0; p < npass; p++)
      for (i = 0; i < NBIN; i++) begin
        rnd        = $random(seed);
        stim[p][i] = rnd[IDW-1:0];
      end
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (irq_done !== 1'b1 && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (irq_done !== 1'b1) stop_on_timeout("done interrupt");
  endtask

  task automatic wait_results();
    int n;
    n = 0;
    while (beat_total - beat_base < exp_bins && n < TMO) begin
      @(negedge clk);
      n++;
    end
    if (beat_total - beat_base < exp_bins) stop_on_timeout("result stream");
    repeat (4) @(negedge clk);  // room for a stray extra beat
  endtask

  // low word and sign-extended high word of every bin
  task automatic check_window();
    int                    b;
    acum_types_pkg::word_t dat;
    for (b = 0; b < NBIN; b++) begin
      reg_read(acum_regs_pkg::MEM_LO_BASE + acum_regs_pkg::reg_adr_t'(4 * b), dat);
      check_word(dat, exp_sum[b][31:0], "bin low word");
      reg_read(acum_regs_pkg::MEM_HI_BASE + acum_regs_pkg::reg_adr_t'(4 * b), dat);
      check_word(dat, acum_types_pkg::word_t'(exp_sum[b] >>> 32), "bin high word");
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    acum_types_pkg::word_t dat;
    int                    p;
    int                    k;
    rst       = 1'b1;
    adc_dat   = '0;
    adc_vld   = 1'b0;
    trg       = 1'b0;
    reg_wen   = 1'b0;
    reg_ren   = 1'b0;
    reg_adr   = '0;
    reg_wdt   = '0;
    bp_on     = 1'b0;
    beat_base = 0;
    exp_bins  = 0;
    for (k = 0; k < 1024; k++) begin
      rnd       = $random(seed);
      bp_pat[k] = rnd[0];
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;

    // reset state and config readback
    reg_read(acum_regs_pkg::REG_CTRL, dat);
    check_word(dat, '0, "ctrl after reset");
    reg_read(acum_regs_pkg::REG_STS, dat);
    check_word(dat, '0, "status after reset");
    check_flag(irq_done, 1'b0, "irq after reset");
    rnd = $random(seed);
    reg_write(acum_regs_pkg::REG_CFG_CNT, rnd);
    reg_read(acum_regs_pkg::REG_CFG_CNT, dat);
    check_word(dat, rnd, "pass count readback");
    rnd = $random(seed);
    reg_write(acum_regs_pkg::REG_CFG_LEN, rnd);
    reg_read(acum_regs_pkg::REG_CFG_LEN, dat);
    check_word(dat, rnd, "frame length readback");

    // full run of four passes
    reg_write(acum_regs_pkg::REG_CFG_LEN, acum_types_pkg::word_t'(NBIN - 1));
    reg_write(acum_regs_pkg::REG_CFG_CNT, 32'd3);
    make_frames(4);
    compute_reference(4);
    beat_base = beat_total;
    exp_bins  = NBIN;
    reg_write(acum_regs_pkg::REG_CTRL, 32'h1);
    for (p = 0; p < 4; p++) begin
      send_gap();
      send_frame(p);
    end
    wait_done();
    wait_results();
    reg_read(acum_regs_pkg::REG_STS, dat);
    check_word(dat, 32'h1, "done bit");
    reg_read(acum_regs_pkg::REG_CTRL, dat);
    check_word(dat, 32'h0, "run after last pass");

    // bins through the memory window
    check_window();

    // two passes under random back-pressure
    reg_write(acum_regs_pkg::REG_CFG_CNT, 32'd1);
    make_frames(2);
    compute_reference(2);
    beat_base = beat_total;
    exp_bins  = NBIN;
    bp_on     = 1'b1;
    reg_write(acum_regs_pkg::REG_CTRL, 32'h1);
    check_flag(irq_done, 1'b0, "done cleared by new run");
    for (p = 0; p < 2; p++) begin
      send_gap();
      send_frame(p);
    end
    wait_done();
    wait_results();
    bp_on = 1'b0;

    // clear halfway through and start a fresh run
    reg_write(acum_regs_pkg::REG_CFG_CNT, 32'd3);
    make_frames(2);
    beat_base = beat_total;
    exp_bins  = 0;  // no sums before the last pass
    reg_write(acum_regs_pkg::REG_CTRL, 32'h1);
    for (p = 0; p < 2; p++) begin
      send_gap();
      send_frame(p);
    end
    reg_read(acum_regs_pkg::REG_STS_CNT, dat);
    check_word(dat, 32'd2, "pass index before clear");
    reg_write(acum_regs_pkg::REG_CTRL, 32'h2);  // stop and clear
    reg_read(acum_regs_pkg::REG_STS_CNT, dat);
    check_word(dat, 32'd0, "pass index after clear");
    make_frames(4);
    compute_reference(4);
    beat_base = beat_total;
    exp_bins  = NBIN;
    reg_write(acum_regs_pkg::REG_CTRL, 32'h1);
    for (p = 0; p < 4; p++) begin
      send_gap();
      send_frame(p);
    end
    wait_done();
    wait_results();
    check_window();

    $display("Result: PASSED");
    $finish;
  end

endmodule : tb_averager

// ==== src.f ====
hdl/acum_types_pkg.sv
hdl/acum_regs_pkg.sv
hdl/frame_slicer.sv
hdl/acum_regs.sv
hdl/acum_core.sv
hdl/averager_top.sv
tb/tb_averager.sv

// ==== run.sh ====
#!/bin/sh
# build the averager testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1

verilator --binary -f src.f --top-module tb_averager -Mdir obj_dir -o tb_averager
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_averager > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: PASSED" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi
